// ==== dv/ccu_checker.sv ====
// CCU transaction checker
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_checker
    import ccu_lib_pkg::*, ccu_biu_pkg::*;
#(
    parameter int NAME_W = 96
) (
    input  logic                       clk,
    input  logic                       i_rst,
    input  logic [`CCU_ARB_DEPTH-1:0]  i_req_valid,
    input  logic [`CCU_ARB_DEPTH-1:0]  i_req_we,
    input  biu_len_t                   i_req_len  [0:`CCU_ARB_DEPTH-1],
    input  logic [`CCU_ADDR_WIDTH-1:0] i_req_addr [0:`CCU_ARB_DEPTH-1],
    input  ccu_line_t                  i_req_data [0:`CCU_ARB_DEPTH-1],
    input  logic [`CCU_ARB_DEPTH-1:0]  i_req_grant,
    input  logic [`CCU_ARB_DEPTH-1:0]  i_req_done,
    input  ccu_line_t                  i_req_rdata,
    input  logic [NAME_W-1:0]          i_test_name [0:`CCU_ARB_DEPTH-1],
    input  ccu_line_t                  i_test_exp  [0:`CCU_ARB_DEPTH-1],
    output int                         o_errors
);

    localparam int DEPTH = `CCU_ARB_DEPTH;

    // Reference memory that stays unknown until written
    ccu_line_t                  ref_mem [0:`CCU_MEM_LINES-1];
    logic                       busy;
    int                         owner;
    logic [DEPTH-1:0]           prev_valid;

    // Request of the transaction in progress as taken at its grant
    logic                       own_we;
    biu_len_t                   own_len;
    logic [`CCU_ADDR_WIDTH-1:0] own_addr;
    ccu_line_t                  own_data;
    logic [NAME_W-1:0]          own_name;
    ccu_line_t                  own_exp;

    initial o_errors = 0;

    function automatic logic [DEPTH-1:0] lowest_valid(input logic [DEPTH-1:0] v);
        return v & (~v + 1'b1);
    endfunction

    // Replace the bytes of the access with its offset aligned down to its size
    function automatic ccu_line_t merge_line(input ccu_line_t old, input ccu_line_t wdata,
                                             input biu_len_t len, input int offset);
        ccu_line_t line;
        int        size;
        int        base;
        case (len)
            BIU_LEN_BYTE: size = 1;
            BIU_LEN_HALF: size = 2;
            BIU_LEN_WORD: size = 4;
            default:      size = `CCU_LINE_SIZE;
        endcase
        base = offset - (offset % size);
        line = old;
        for (int b = base; b < base + size; b++) begin
            line.bytes[b] = wdata.bytes[b];
        end
        return line;
    endfunction

    task automatic finish_transaction();
        int idx;
        int offset;
        idx    = (own_addr / `CCU_LINE_SIZE) % `CCU_MEM_LINES;
        offset = own_addr % `CCU_LINE_SIZE;
        if (own_we) begin
            ref_mem[idx] = merge_line(ref_mem[idx], own_data, own_len, offset);
        end else begin
            if (i_req_rdata !== own_exp) begin
                $display("error: test %0s expected %h actual %h", own_name, own_exp, i_req_rdata);
                o_errors++;
            end
            if (i_req_rdata !== ref_mem[idx]) begin
                $display("error: test %0s expected %h actual %h from the reference memory",
                         own_name, ref_mem[idx], i_req_rdata);
                o_errors++;
            end
        end
    endtask

    // Registered outputs and held inputs are all settled at the falling edge
    always @(negedge clk) begin
        if (i_rst) begin
            busy       = 1'b0;
            prev_valid = '0;
        end else begin
            if (i_req_done !== '0) begin
                if (!busy) begin
                    $display("Done pulse %b arrived with no transaction in progress", i_req_done);
                    o_errors++;
                end else if (i_req_done !== (DEPTH'(1) << owner)) begin
                    $display("Done pulse %b does not match requestor %0d that owns the bus",
                             i_req_done, owner);
                    o_errors++;
                end else begin
                    finish_transaction();
                end
                busy = 1'b0;
            end
            if (i_req_grant !== '0) begin
                if (busy) begin
                    $display("Grant %b came while requestor %0d was still busy",
                             i_req_grant, owner);
                    o_errors++;
                end
                if (i_req_grant !== lowest_valid(prev_valid)) begin
                    $display("Grant %b is not the lowest valid requestor of %b",
                             i_req_grant, prev_valid);
                    o_errors++;
                end
                for (int k = DEPTH - 1; k >= 0; k--) begin
                    if (i_req_grant[k]) begin
                        owner = k;
                    end
                end
                own_we   = i_req_we[owner];
                own_len  = i_req_len[owner];
                own_addr = i_req_addr[owner];
                own_data = i_req_data[owner];
                own_name = i_test_name[owner];
                own_exp  = i_test_exp[owner];
                busy     = 1'b1;
            end
            prev_valid = i_req_valid;
        end
    end

endmodule

// ==== dv/ccu_tb.sv ====
// CCU testbench top
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_tb
    import ccu_lib_pkg::*, ccu_biu_pkg::*;
();

    localparam int DEPTH        = `CCU_ARB_DEPTH;
    localparam int LINE_W       = 8 * `CCU_LINE_SIZE;
    localparam int MAX_TESTS    = 32;
    localparam int NAME_W       = 96;
    localparam int DONE_TIMEOUT = 100;

    logic                       clk;
    logic                       i_rst;
    logic [DEPTH-1:0]           req_valid;
    logic [DEPTH-1:0]           req_we;
    biu_len_t                   req_len  [0:DEPTH-1];
    logic [`CCU_ADDR_WIDTH-1:0] req_addr [0:DEPTH-1];
    ccu_line_t                  req_data [0:DEPTH-1];
    logic [DEPTH-1:0]           req_grant;
    logic [DEPTH-1:0]           req_done;
    ccu_line_t                  req_rdata;

    // Name and expected read line of the test each requestor presents
    logic [NAME_W-1:0]          cur_name [0:DEPTH-1];
    ccu_line_t                  cur_exp  [0:DEPTH-1];

    // Transactions as read from the tests file
    int                         t_group [0:MAX_TESTS-1];
    logic [NAME_W-1:0]          t_name  [0:MAX_TESTS-1];
    int                         t_req   [0:MAX_TESTS-1];
    int                         t_start [0:MAX_TESTS-1];
    logic                       t_we    [0:MAX_TESTS-1];
    biu_len_t                   t_len   [0:MAX_TESTS-1];
    logic [`CCU_ADDR_WIDTH-1:0] t_addr  [0:MAX_TESTS-1];
    ccu_line_t                  t_data  [0:MAX_TESTS-1];
    ccu_line_t                  t_exp   [0:MAX_TESTS-1];
    int                         num_tests;

    // Test index each requestor runs in the current group, or -1
    int                         slot [0:DEPTH-1];
    int                         check_errors;
    int                         timeout_errors;
    int                         file_errors;

    ccu_top u_dut (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_req_valid (req_valid),
        .i_req_we    (req_we),
        .i_req_len   (req_len),
        .i_req_addr  (req_addr),
        .i_req_data  (req_data),
        .o_req_grant (req_grant),
        .o_req_done  (req_done),
        .o_req_data  (req_rdata)
    );

    ccu_checker #(
        .NAME_W (NAME_W)
    ) u_checker (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_req_valid (req_valid),
        .i_req_we    (req_we),
        .i_req_len   (req_len),
        .i_req_addr  (req_addr),
        .i_req_data  (req_data),
        .i_req_grant (req_grant),
        .i_req_done  (req_done),
        .i_req_rdata (req_rdata),
        .i_test_name (cur_name),
        .i_test_exp  (cur_exp),
        .o_errors    (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic read_tests();
        int                         fd;
        int                         n;
        int                         grp;
        int                         req;
        int                         start;
        int                         we;
        int                         len;
        logic [8*200-1:0]           text;
        logic [NAME_W-1:0]          name;
        logic [`CCU_ADDR_WIDTH-1:0] addr;
        logic [LINE_W-1:0]          data;
        logic [LINE_W-1:0]          exp;
        fd = $fopen("dv/ccu_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file dv/ccu_tests.txt");
            file_errors++;
            return;
        end
        while (!$feof(fd)) begin
            text = '0;
            n = $fgets(text, fd);
            // Comment and blank lines do not scan all nine fields
            if (n > 0) begin
                n = $sscanf(text, "%d %s %d %d %d %d %h %h %h",
                            grp, name, req, start, we, len, addr, data, exp);
            end
            if (n == 9 && (num_tests >= MAX_TESTS || req < 0 || req >= DEPTH)) begin
                $display("Tests file line for test %0s cannot be used", name);
                file_errors++;
            end else if (n == 9) begin
                t_group[num_tests] = grp;
                t_name[num_tests]  = name;
                t_req[num_tests]   = req;
                t_start[num_tests] = start;
                t_we[num_tests]    = (we != 0);
                t_len[num_tests]   = biu_len_t'(len);
                t_addr[num_tests]  = addr;
                t_data[num_tests]  = data;
                t_exp[num_tests]   = exp;
                num_tests++;
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("The tests file holds no transactions");
            file_errors++;
        end
    endtask

    // Present one request and hold it until its done pulse
    task automatic serve_slot(input int k);
        int   e;
        int   cycles;
        logic got;
        e = slot[k];
        if (e < 0) begin
            return;
        end
        repeat (t_start[e]) begin
            @(posedge clk);
            #1;
        end
        cur_name[k]  = t_name[e];
        cur_exp[k]   = t_exp[e];
        req_we[k]    = t_we[e];
        req_len[k]   = t_len[e];
        req_addr[k]  = t_addr[e];
        req_data[k]  = t_data[e];
        req_valid[k] = 1'b1;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            got = req_done[k];
            cycles++;
        end
        if (!got) begin
            $display("Timeout: no done pulse arrived for requestor %0d in test %0s",
                     k, t_name[e]);
            timeout_errors++;
        end
        req_valid[k] = 1'b0;
    endtask

    initial begin
        int e;
        int g;
        int gap;
        i_rst     = 1'b1;
        req_valid = '0;
        req_we    = '0;
        for (int k = 0; k < DEPTH; k++) begin
            req_len[k]  = BIU_LEN_BYTE;
            req_addr[k] = '0;
            req_data[k] = '0;
            cur_name[k] = '0;
            cur_exp[k]  = '0;
        end
        num_tests      = 0;
        timeout_errors = 0;
        file_errors    = 0;
        gap = $urandom(41);
        read_tests();

        repeat (4) @(posedge clk);
        #1;
        i_rst = 1'b0;
        // Quiet cycles where grant and done must stay low
        repeat (3) begin
            @(posedge clk);
            #1;
        end

        e = 0;
        while (e < num_tests) begin
            g = t_group[e];
            for (int k = 0; k < DEPTH; k++) begin
                slot[k] = -1;
            end
            while (e < num_tests && t_group[e] == g) begin
                if (slot[t_req[e]] >= 0) begin
                    $display("Group %0d gives requestor %0d more than one test", g, t_req[e]);
                    file_errors++;
                end else begin
                    slot[t_req[e]] = e;
                end
                e++;
            end
            fork
                serve_slot(0);
                serve_slot(1);
                serve_slot(2);
            join
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end

        repeat (10) begin
            @(posedge clk);
            #1;
        end
        $display("Errors: %0d from checks, %0d timeouts, %0d in the tests file",
                 check_errors, timeout_errors, file_errors);
        if (check_errors == 0 && timeout_errors == 0 && file_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== dv/ccu_tests.txt ====
# group name req start we len addr data expect, len is 0 byte 1 half 2 word 3 line
# Same group presents together, start delays a request by cycles, expect is checked on reads
0 line_wr  0 0 1 3 00000100 0123456789abcdeffedcba9876543210 0
1 line_rd  0 0 0 3 00000100 0 0123456789abcdeffedcba9876543210
2 base_wr  1 0 1 3 00000200 00112233445566778899aabbccddeeff 0
3 byte_wr  1 0 1 0 00000205 f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff 0
4 half_wr  1 0 1 1 0000020b f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff 0
5 word_wr  1 0 1 2 0000020e f0f1f2f3f4f5f6f7f8f9fafbfcfdfeff 0
6 merge_rd 1 0 0 3 00000200 0 f0f1f2f3f4f566778899fabbccddeeff
7 byte_rd  2 0 0 0 00000207 0 f0f1f2f3f4f566778899fabbccddeeff
8 par_wr0  0 0 1 3 00000300 0f0e0d0c0b0a09080706050403020100 0
8 par_wr1  1 0 1 3 00000310 1f1e1d1c1b1a19181716151413121110 0
8 par_wr2  2 0 1 3 00000320 2f2e2d2c2b2a29282726252423222120 0
9 par_rd0  0 0 0 3 00000320 0 2f2e2d2c2b2a29282726252423222120
9 par_rd1  1 0 0 3 00000300 0 0f0e0d0c0b0a09080706050403020100
9 par_rd2  2 0 0 3 00000310 0 1f1e1d1c1b1a19181716151413121110
10 ord_wd  0 0 1 2 00000304 3333333322222222deadbeef11111111 0
10 ord_wb  1 0 1 0 00000300 77777777777777777777777777777777 0
10 ord_rd  2 0 0 3 00000300 0 0f0e0d0c0b0a0908deadbeef03020177
11 late_r2 2 0 0 3 00000310 0 1f1e1d1c1b1a19181716151413121110
11 late_r0 0 3 0 3 00000320 0 2f2e2d2c2b2a29282726252423222120
11 late_w1 1 5 1 3 00000100 a5a5a5a55a5a5a5ac3c3c3c33c3c3c3c 0
12 late_rd 0 0 0 3 00000100 0 a5a5a5a55a5a5a5ac3c3c3c33c3c3c3c
13 wrap_rd 1 0 0 2 00001100 0 a5a5a5a55a5a5a5ac3c3c3c33c3c3c3c

// ==== sources.f ====
+incdir+src
src/ccu_lib_pkg.sv
src/ccu_biu_pkg.sv
src/ccu_arb.sv
src/ccu_biu.sv
src/ccu_mem.sv
src/ccu_top.sv
dv/ccu_checker.sv
dv/ccu_tb.sv

// ==== src/ccu_arb.sv ====
// CCU priority arbiter
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_arb
    import ccu_lib_pkg::*, ccu_biu_pkg::*;
(
    input  logic                       clk,
    input  logic                       i_rst,

    // Requestor side
    input  logic [`CCU_ARB_DEPTH-1:0]  i_req_valid,
    input  logic [`CCU_ARB_DEPTH-1:0]  i_req_we,
    input  biu_len_t                   i_req_len  [0:`CCU_ARB_DEPTH-1],
    input  logic [`CCU_ADDR_WIDTH-1:0] i_req_addr [0:`CCU_ARB_DEPTH-1],
    input  ccu_line_t                  i_req_data [0:`CCU_ARB_DEPTH-1],
    output logic [`CCU_ARB_DEPTH-1:0]  o_req_grant,
    output logic [`CCU_ARB_DEPTH-1:0]  o_req_done,
    output ccu_line_t                  o_req_data,

    // BIU side
    input  logic                       i_biu_done,
    input  ccu_line_t                  i_biu_rdata,
    output logic                       o_biu_en,
    output biu_func_t                  o_biu_func,
    output biu_len_t                   o_biu_len,
    output logic [`CCU_ADDR_WIDTH-1:0] o_biu_addr,
    output ccu_line_t                  o_biu_data
);

    localparam int IDX_W = (`CCU_ARB_DEPTH > 1) ? $clog2(`CCU_ARB_DEPTH) : 1;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_BUSY = 2'b01,
        ARB_DONE = 2'b10
    } arb_state_t;

    arb_state_t                state_r;
    arb_state_t                state_next;
    logic [`CCU_ARB_DEPTH-1:0] select;
    logic [IDX_W-1:0]          sel_idx;
    logic [IDX_W-1:0]          idx_r;
    logic                      any_valid;
    logic [`CCU_ARB_DEPTH-1:0] grant_next;
    logic [`CCU_ARB_DEPTH-1:0] done_next;
    logic                      en_next;

    // Lowest valid index wins, as a one-hot vector
    always_comb begin
        select = '0;
        for (int k = 0; k < `CCU_ARB_DEPTH; k++) begin
            if (i_req_valid[k] && (select == '0)) begin
                select[k] = 1'b1;
            end
        end
    end

    // One-hot winner to binary index for the request mux
    always_comb begin
        sel_idx = '0;
        for (int k = 0; k < `CCU_ARB_DEPTH; k++) begin
            if (select[k]) begin
                sel_idx = sel_idx | IDX_W'(k);
            end
        end
    end

    assign any_valid = |select;

    // One transaction at a time, with a single DONE cycle before sampling again
    always_comb begin
        state_next = state_r;
        grant_next = '0;
        done_next  = '0;
        en_next    = 1'b0;
        unique case (state_r)
            ARB_IDLE: begin
                grant_next = select;
                if (any_valid) begin
                    state_next = ARB_BUSY;
                end
            end
            ARB_BUSY: begin
                done_next[idx_r] = i_biu_done;
                // Enable is dropped on the cycle the BIU reports done
                en_next = i_biu_done ? 1'b0 : i_req_valid[idx_r];
                if (i_biu_done) begin
                    state_next = ARB_DONE;
                end
            end
            default: begin
                state_next = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_r     <= ARB_IDLE;
            idx_r       <= '0;
            o_req_grant <= '0;
            o_req_done  <= '0;
            o_biu_en    <= 1'b0;
        end else begin
            state_r     <= state_next;
            o_req_grant <= grant_next;
            o_req_done  <= done_next;
            o_biu_en    <= en_next;
            // The winner index is frozen once the transaction leaves IDLE
            if (state_r == ARB_IDLE) begin
                idx_r <= sel_idx;
            end
        end
    end

    // Request fields follow the held winner and read data is caught on BIU done
    always_ff @(posedge clk) begin
        o_biu_func <= i_req_we[idx_r] ? BIU_FUNC_WRITE : BIU_FUNC_READ;
        o_biu_len  <= i_req_len[idx_r];
        o_biu_addr <= i_req_addr[idx_r];
        o_biu_data <= i_req_data[idx_r];
        if (i_biu_done) begin
            o_req_data <= i_biu_rdata;
        end
    end

endmodule

// ==== src/ccu_biu.sv ====
// CCU bus interface unit
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_biu
    import ccu_lib_pkg::*, ccu_biu_pkg::*;
(
    input  logic                          clk,
    input  logic                          i_rst,

    // Request from the arbiter
    input  logic                          i_en,
    input  biu_func_t                     i_func,
    input  biu_len_t                      i_len,
    input  logic [`CCU_ADDR_WIDTH-1:0]    i_addr,
    input  ccu_line_t                     i_data,
    output logic                          o_done,
    output ccu_line_t                     o_rdata,

    // Memory port
    input  ccu_line_t                     i_mem_rline,
    output logic                          o_mem_we,
    output logic [`CCU_MEM_IDX_WIDTH-1:0] o_mem_widx,
    output ccu_line_t                     o_mem_wline,
    output logic [`CCU_MEM_IDX_WIDTH-1:0] o_mem_ridx
);

    localparam int OFF_W = `CCU_LINE_OFFSET_WIDTH;
    localparam int IDX_W = `CCU_MEM_IDX_WIDTH;
    localparam int CNT_W = $clog2(`CCU_MEM_LATENCY + 1);

    typedef enum logic [2:0] {
        BIU_IDLE    = 3'b000,
        BIU_WAIT    = 3'b001,
        BIU_READ    = 3'b010,
        BIU_DONE    = 3'b011,
        BIU_RECOVER = 3'b100
    } biu_state_t;

    biu_state_t       state_r;
    logic [CNT_W-1:0] cnt_r;
    biu_func_t        func_r;
    biu_len_t         len_r;
    logic [IDX_W-1:0] idx_r;
    logic [OFF_W-1:0] off_r;
    ccu_line_t        data_r;
    logic [OFF_W-1:0] half_lo;
    logic [OFF_W-1:0] half_hi;
    logic [OFF_W-3:0] word_off;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_r <= BIU_IDLE;
            cnt_r   <= '0;
        end else begin
            unique case (state_r)
                BIU_IDLE: begin
                    cnt_r <= '0;
                    if (i_en) begin
                        state_r <= BIU_WAIT;
                    end
                end
                BIU_WAIT: begin
                    cnt_r <= cnt_r + 1'b1;
                    if (cnt_r == CNT_W'(`CCU_MEM_LATENCY - 1)) begin
                        state_r <= BIU_READ;
                    end
                end
                BIU_READ:    state_r <= BIU_DONE;
                // One idle cycle lets the registered enable from the arbiter fall
                BIU_DONE:    state_r <= BIU_RECOVER;
                default:     state_r <= BIU_IDLE;
            endcase
        end
    end

    // Capture the request on the first enabled idle cycle
    always_ff @(posedge clk) begin
        if ((state_r == BIU_IDLE) && i_en) begin
            func_r <= i_func;
            len_r  <= i_len;
            idx_r  <= i_addr[OFF_W +: IDX_W];
            off_r  <= i_addr[OFF_W-1:0];
            data_r <= i_data;
        end
    end

    // Offsets aligned down to the access size
    assign half_lo  = {off_r[OFF_W-1:1], 1'b0};
    assign half_hi  = {off_r[OFF_W-1:1], 1'b1};
    assign word_off = off_r[OFF_W-1:2];

    // Old line with the addressed lanes replaced by the request data
    always_comb begin
        o_mem_wline = i_mem_rline;
        unique case (len_r)
            BIU_LEN_BYTE: o_mem_wline.bytes[off_r] = data_r.bytes[off_r];
            BIU_LEN_HALF: begin
                o_mem_wline.bytes[half_lo] = data_r.bytes[half_lo];
                o_mem_wline.bytes[half_hi] = data_r.bytes[half_hi];
            end
            BIU_LEN_WORD: o_mem_wline.words[word_off] = data_r.words[word_off];
            default:      o_mem_wline = data_r;
        endcase
    end

    // The stored line is on the memory output during the DONE cycle
    assign o_mem_ridx = idx_r;
    assign o_mem_widx = idx_r;
    assign o_mem_we   = (state_r == BIU_DONE) && (func_r == BIU_FUNC_WRITE);
    assign o_done     = (state_r == BIU_DONE);
    assign o_rdata    = i_mem_rline;

endmodule

// ==== src/ccu_biu_pkg.sv ====
// Bus transaction encodings
package ccu_biu_pkg;

    localparam int BIU_FUNC_WIDTH = 1;
    localparam int BIU_LEN_WIDTH  = 2;

    // Direction of a BIU transaction
    typedef enum logic [BIU_FUNC_WIDTH-1:0] {
        BIU_FUNC_READ  = 1'b0,
        BIU_FUNC_WRITE = 1'b1
    } biu_func_t;

    // Access size of a BIU transaction
    // Reads always return the full line whatever the size
    typedef enum logic [BIU_LEN_WIDTH-1:0] {
        BIU_LEN_BYTE = 2'b00,
        BIU_LEN_HALF = 2'b01,
        BIU_LEN_WORD = 2'b10,
        BIU_LEN_LINE = 2'b11
    } biu_len_t;

endpackage

// ==== src/ccu_lib_pkg.sv ====
// Line data layout types
`include "ccu_params.svh"

package ccu_lib_pkg;

    // A line holds this many bytes and this many 32-bit words
    localparam int LINE_BYTES = `CCU_LINE_SIZE;
    localparam int LINE_WORDS = `CCU_LINE_SIZE / 4;

    typedef logic [7:0]  ccu_byte_t;
    typedef logic [31:0] ccu_word_t;

    // One line seen either as byte lanes or as word lanes
    // Lane 0 sits in the least significant bits in both views
    typedef union packed {
        ccu_byte_t [LINE_BYTES-1:0] bytes;
        ccu_word_t [LINE_WORDS-1:0] words;
    } ccu_line_t;

endpackage

// ==== src/ccu_mem.sv ====
// CCU line memory
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_mem
    import ccu_lib_pkg::*;
(
    input  logic                          clk,

    // Write port
    input  logic                          i_we,
    input  logic [`CCU_MEM_IDX_WIDTH-1:0] i_widx,
    input  ccu_line_t                     i_wline,

    // Read port with data one cycle after the index
    input  logic [`CCU_MEM_IDX_WIDTH-1:0] i_ridx,
    output ccu_line_t                     o_rline
);

    // Contents start unknown and are filled by writes
    ccu_line_t mem [0:`CCU_MEM_LINES-1];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_widx] <= i_wline;
        end
    end

    // A read of the line being written returns the old contents
    always_ff @(posedge clk) begin
        o_rline <= mem[i_ridx];
    end

endmodule

// ==== src/ccu_params.svh ====
// CCU configuration parameters
`ifndef CCU_PARAMS_SVH
`define CCU_PARAMS_SVH

// Byte address width
`define CCU_ADDR_WIDTH 32

// Line size in bytes, which gives a 128-bit line
`define CCU_LINE_SIZE 16

// Number of requestors sharing the BIU
`define CCU_ARB_DEPTH 3

// Memory depth in lines and access latency in cycles
`define CCU_MEM_LINES 64
`define CCU_MEM_LATENCY 4

// Derived address field widths
`define CCU_LINE_OFFSET_WIDTH $clog2(`CCU_LINE_SIZE)
`define CCU_MEM_IDX_WIDTH $clog2(`CCU_MEM_LINES)

`endif

// ==== src/ccu_top.sv ====
// CCU top level
`timescale 1ns/1ps
`include "ccu_params.svh"

module ccu_top
    import ccu_lib_pkg::*, ccu_biu_pkg::*;
(
    input  logic                       clk,
    input  logic                       i_rst,

    input  logic [`CCU_ARB_DEPTH-1:0]  i_req_valid,
    input  logic [`CCU_ARB_DEPTH-1:0]  i_req_we,
    input  biu_len_t                   i_req_len  [0:`CCU_ARB_DEPTH-1],
    input  logic [`CCU_ADDR_WIDTH-1:0] i_req_addr [0:`CCU_ARB_DEPTH-1],
    input  ccu_line_t                  i_req_data [0:`CCU_ARB_DEPTH-1],
    output logic [`CCU_ARB_DEPTH-1:0]  o_req_grant,
    output logic [`CCU_ARB_DEPTH-1:0]  o_req_done,
    output ccu_line_t                  o_req_data
);

    // Arbiter to BIU
    logic                          biu_en;
    biu_func_t                     biu_func;
    biu_len_t                      biu_len;
    logic [`CCU_ADDR_WIDTH-1:0]    biu_addr;
    ccu_line_t                     biu_data;
    logic                          biu_done;
    ccu_line_t                     biu_rdata;

    // BIU to memory
    logic                          mem_we;
    logic [`CCU_MEM_IDX_WIDTH-1:0] mem_widx;
    ccu_line_t                     mem_wline;
    logic [`CCU_MEM_IDX_WIDTH-1:0] mem_ridx;
    ccu_line_t                     mem_rline;

    ccu_arb u_arb (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .i_req_we    (i_req_we),
        .i_req_len   (i_req_len),
        .i_req_addr  (i_req_addr),
        .i_req_data  (i_req_data),
        .o_req_grant (o_req_grant),
        .o_req_done  (o_req_done),
        .o_req_data  (o_req_data),
        .i_biu_done  (biu_done),
        .i_biu_rdata (biu_rdata),
        .o_biu_en    (biu_en),
        .o_biu_func  (biu_func),
        .o_biu_len   (biu_len),
        .o_biu_addr  (biu_addr),
        .o_biu_data  (biu_data)
    );

    ccu_biu u_biu (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_en        (biu_en),
        .i_func      (biu_func),
        .i_len       (biu_len),
        .i_addr      (biu_addr),
        .i_data      (biu_data),
        .o_done      (biu_done),
        .o_rdata     (biu_rdata),
        .i_mem_rline (mem_rline),
        .o_mem_we    (mem_we),
        .o_mem_widx  (mem_widx),
        .o_mem_wline (mem_wline),
        .o_mem_ridx  (mem_ridx)
    );

    ccu_mem u_mem (
        .clk     (clk),
        .i_we    (mem_we),
        .i_widx  (mem_widx),
        .i_wline (mem_wline),
        .i_ridx  (mem_ridx),
        .o_rline (mem_rline)
    );

endmodule
